/* ks_adder_vectors.txt */
// Columns: a b cin expected_sum expected_cout, all in hex
// One addition per line, five words per line
// Zero and carry-in only
00000000 00000000 0 00000000 0
00000000 00000000 1 00000001 0
7fffffff 00000000 1 80000000 0
ffffffff 00000000 1 00000000 1
// Carry through every level
ffffffff 00000001 0 00000000 1
fffffffe 00000001 1 00000000 1
ffffffff ffffffff 0 fffffffe 1
ffffffff ffffffff 1 ffffffff 1
fffffff0 00000010 0 00000000 1
ffff0000 0000ffff 1 00000000 1
80000001 7fffffff 0 00000000 1
99999999 66666667 0 00000000 1
89abcdef 76543211 0 00000000 1
// Alternating bit patterns
aaaaaaaa 55555555 0 ffffffff 0
aaaaaaaa 55555555 1 00000000 1
55555555 aaaaaaaa 0 ffffffff 0
55555555 55555555 0 aaaaaaaa 0
55555555 55555555 1 aaaaaaab 0
aaaaaaaa aaaaaaaa 0 55555554 1
aaaaaaaa aaaaaaaa 1 55555555 1
0f0f0f0f f0f0f0f0 0 ffffffff 0
0f0f0f0f f0f0f0f0 1 00000000 1
33333333 cccccccc 1 00000000 1
00ff00ff 00ff00ff 0 01fe01fe 0
01010101 01010101 0 02020202 0
// Carries stopping at group edges
0000000f 00000001 0 00000010 0
000000ff 00000001 0 00000100 0
0000ffff 00000001 0 00010000 0
00ffffff 00000001 0 01000000 0
00008000 00008000 0 00010000 0
0000ffff 0000ffff 1 0001ffff 0
7fffffff 00000001 0 80000000 0
7fffffff 7fffffff 1 ffffffff 0
// Top bit and mixed values
80000000 80000000 0 00000000 1
80000000 80000000 1 00000001 1
c0000000 40000000 0 00000000 1
00000001 fffffffe 0 ffffffff 0
12345678 87654321 0 99999999 0
12345678 87654321 1 9999999a 0
89abcdef 76543210 0 ffffffff 0
11111111 22222222 1 33333334 0
deadbeef 00000001 0 deadbef0 0

/* build.f */
+incdir+.
ks_pkg.sv
ks_group_if.sv
ks_pg_stage.sv
ks_prefix_front.sv
ks_prefix_back.sv
ks_adder_top.sv
ks_adder_properties.sv
tb_ks_adder.sv

/* Makefile */
# Verilator flow for the Kogge-Stone adder testbench
# Override any variable on the command line, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= tb_ks_adder
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "Failure reported in $(LOG)"; \
		exit 1; \
	elif ! grep -q "Simulation PASSED" $(LOG); then \
		echo "Run ended without a result line, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_ks_adder.sv */
`timescale 1ns/10ps
`include "ks_params.svh"

module tb_ks_adder import ks_pkg::*; ();

    localparam int RESET_CYCLES   = 16;
    localparam int NUM_VECTORS    = 42;
    localparam int NUM_RANDOM     = 200;
    localparam int VEC_FIELDS     = 5;
    localparam int VEC_WORDS      = NUM_VECTORS * VEC_FIELDS;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_VECTORS + NUM_RANDOM + `KS_LATENCY + 20;

    logic     clk;
    logic     rst_n;
    operand_t a;
    operand_t b;
    logic     cin;
    operand_t sum;
    logic     cout;

    // Five words per vector for a, b, cin, sum and cout
    logic [`KS_WIDTH-1:0] vec_mem [0:VEC_WORDS-1];

    // Expected {cout, sum} per clock after reset release
    logic [`KS_WIDTH:0]   expect_q [$];

    logic [31:0]          lcg_state;
    int                   cycle_count = 0;

    ks_adder_top uut (
        .clk   (clk),
        .rst_n (rst_n),
        .a     (a),
        .b     (b),
        .cin   (cin),
        .sum   (sum),
        .cout  (cout)
    );

    always #4 clk = ~clk;

    ////////////////////
    // Helpers
    ////////////////////

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "Run stopped at %0t", $time);
    endtask

    task automatic report_mismatch(
        input string    name,
        input operand_t expected,
        input operand_t actual
    );
        string line;

        line = $sformatf("FAILED at %0t: %s expected %0h, got %0h",
                         $time, name, expected, actual);
        abort_run(line);
    endtask

    task drive_step(
        input operand_t           op_a,
        input operand_t           op_b,
        input logic               op_cin,
        input logic [`KS_WIDTH:0] expected
    );
        a   <= op_a;
        b   <= op_b;
        cin <= op_cin;
        expect_q.push_back(expected);
    endtask

    // Full 33-bit sum of both operands and the carry-in
    function automatic logic [`KS_WIDTH:0] expected_total(
        input operand_t op_a,
        input operand_t op_b,
        input logic     op_cin
    );
        return {1'b0, op_a} + {1'b0, op_b} + {{`KS_WIDTH{1'b0}}, op_cin};
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    ////////////////////
    // Output checks
    ////////////////////

    // Outputs settle well before the falling edge
    always @(negedge clk) begin
        logic [`KS_WIDTH:0] expected;

        if (!rst_n) begin
            assert (sum === '0) else report_mismatch("sum", '0, sum);
            assert (cout === 1'b0) else report_mismatch("cout", '0, operand_t'(cout));
        end else if (expect_q.size() > 0) begin
            expected = expect_q.pop_front();
            assert (sum === expected[`KS_WIDTH-1:0])
                else report_mismatch("sum", expected[`KS_WIDTH-1:0], sum);
            assert (cout === expected[`KS_WIDTH])
                else report_mismatch("cout", operand_t'(expected[`KS_WIDTH]), operand_t'(cout));
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        assert (cycle_count < TIMEOUT_CYCLES)
            else abort_run($sformatf("Timeout: run still going after %0d clock cycles",
                                     cycle_count));
    end

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        operand_t rnd_a;
        operand_t rnd_b;
        logic     rnd_cin;
        int       base;

        $timeformat(-9, 2, " ns", 0);
        clk       = 1'b0;
        rst_n     = 1'b0;
        // Nonzero operands while the pipeline is held in reset
        a         = '1;
        b         = '1;
        cin       = 1'b1;
        lcg_state = 32'h70f0_79c1;

        for (int i = 0; i < VEC_WORDS; i++) begin
            vec_mem[i] = 32'hbad0_0000 | i;
        end
        $readmemh("ks_adder_vectors.txt", vec_mem);
        for (int i = 0; i < NUM_VECTORS; i++) begin
            base = i * VEC_FIELDS;
            assert (vec_mem[base+2] < 2 && vec_mem[base+4] < 2)
                else abort_run($sformatf("Vector file line %0d is malformed or missing", i));
        end

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        // Pipeline still drains reset state for the first results
        for (int k = 0; k < `KS_LATENCY; k++) begin
            expect_q.push_back('0);
        end

        for (int i = 0; i < NUM_VECTORS; i++) begin
            base = i * VEC_FIELDS;
            if (i > 0) begin
                @(posedge clk);
            end
            drive_step(vec_mem[base], vec_mem[base+1], vec_mem[base+2][0],
                       {vec_mem[base+4][0], vec_mem[base+3]});
        end

        // Back-to-back random sets with three in flight
        for (int i = 0; i < NUM_RANDOM; i++) begin
            lcg_state = lcg_next(lcg_state);
            rnd_a     = lcg_state;
            lcg_state = lcg_next(lcg_state);
            rnd_b     = lcg_state;
            lcg_state = lcg_next(lcg_state);
            rnd_cin   = lcg_state[31];
            @(posedge clk);
            drive_step(rnd_a, rnd_b, rnd_cin, expected_total(rnd_a, rnd_b, rnd_cin));
        end

        while (expect_q.size() > 0) begin
            @(posedge clk);
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* ks_adder_properties.sv */
`timescale 1ns/10ps
`include "ks_params.svh"

module ks_adder_properties import ks_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input operand_t a,
    input operand_t b,
    input logic     cin,
    input operand_t sum,
    input logic     cout
);

    // Cycles since reset release, saturating at the latency
    int unsigned run_cycles;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_cycles <= 0;
        end else if (run_cycles < `KS_LATENCY) begin
            run_cycles <= run_cycles + 1;
        end
    end

    ////////////////////
    // Result and reset
    ////////////////////

    property p_sum_matches_operands;
        @(posedge clk) (rst_n && run_cycles == `KS_LATENCY) |->
            ({cout, sum} == ({1'b0, $past(a, `KS_LATENCY)}
                + {1'b0, $past(b, `KS_LATENCY)}
                + {{`KS_WIDTH{1'b0}}, $past(cin, `KS_LATENCY)}));
    endproperty

    property p_reset_clears_outputs;
        @(posedge clk) (!rst_n && !$past(rst_n)) |-> (sum == '0 && cout == 1'b0);
    endproperty

    a_sum_matches_operands: assert property (p_sum_matches_operands)
        else $error("sum and cout differ from a + b + cin of three cycles earlier");

    a_reset_clears_outputs: assert property (p_reset_clears_outputs)
        else $error("sum or cout not zero while reset is held");

endmodule

bind ks_adder_top ks_adder_properties u_properties (
    .clk   (clk),
    .rst_n (rst_n),
    .a     (a),
    .b     (b),
    .cin   (cin),
    .sum   (sum),
    .cout  (cout)
);

/* ks_adder_top.sv */
`timescale 1ns/10ps

module ks_adder_top import ks_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  operand_t a,
    input  operand_t b,
    input  logic     cin,
    output operand_t sum,
    output logic     cout
);

    // Entry stage to front levels
    ks_group_if pg_link ();

    // Front levels to back levels
    ks_group_if mid_link ();

    ////////////////////
    // Pipeline stages
    ////////////////////

    ks_pg_stage u_pg_stage (
        .clk   (clk),
        .rst_n (rst_n),
        .a     (a),
        .b     (b),
        .cin   (cin),
        .pg    (pg_link)
    );

    ks_prefix_front u_prefix_front (
        .clk   (clk),
        .rst_n (rst_n),
        .pg_in (pg_link),
        .mid   (mid_link)
    );

    // Last levels, sum xor and cout
    ks_prefix_back u_prefix_back (
        .clk   (clk),
        .rst_n (rst_n),
        .mid   (mid_link),
        .sum   (sum),
        .cout  (cout)
    );

endmodule

/* ks_prefix_back.sv */
`timescale 1ns/10ps
`include "ks_params.svh"

module ks_prefix_back import ks_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    ks_group_if.dst  mid,
    output operand_t sum,
    output logic     cout
);

    // Index split holds the middle register words
    pg_word_t g_lvl [`KS_SPLIT_LEVEL:`KS_LEVELS];
    pg_word_t a_lvl [`KS_SPLIT_LEVEL:`KS_LEVELS];

    // Carry out of each bit, top bit still without the carry-in
    pg_word_t carry;
    operand_t sum_next;
    logic     cout_next;

    ////////////////////
    // Remaining levels
    ////////////////////

    always_comb begin
        g_lvl[`KS_SPLIT_LEVEL] = mid.g;
        a_lvl[`KS_SPLIT_LEVEL] = mid.a;
        for (int lvl = `KS_SPLIT_LEVEL + 1; lvl <= `KS_LEVELS; lvl++) begin
            prefix_level(
                lvl,
                mid.cin,
                g_lvl[lvl-1],
                a_lvl[lvl-1],
                g_lvl[lvl],
                a_lvl[lvl]
            );
        end
    end

    assign carry = g_lvl[`KS_LEVELS];

    ////////////////////
    // Sum and carry-out
    ////////////////////

    always_comb begin
        sum_next[0] = mid.p[0] ^ mid.cin;
        for (int i = 1; i < `KS_WIDTH; i++) begin
            sum_next[i] = mid.p[i] ^ carry[i-1];
        end
    end

    // Whole-word group closed with the carry-in
    assign cout_next = grey_dot(
        carry[`KS_WIDTH-1],
        a_lvl[`KS_LEVELS][`KS_WIDTH-1],
        mid.cin
    );

    ////////////////////
    // Output register
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum  <= '0;
            cout <= 1'b0;
        end else begin
            sum  <= sum_next;
            cout <= cout_next;
        end
    end

endmodule

/* ks_prefix_front.sv */
`timescale 1ns/10ps
`include "ks_params.svh"

module ks_prefix_front import ks_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    ks_group_if.dst pg_in,
    ks_group_if.src mid
);

    // Index 0 holds the entry words, index k the words after level k
    pg_word_t g_lvl [0:`KS_SPLIT_LEVEL];
    pg_word_t a_lvl [0:`KS_SPLIT_LEVEL];

    ////////////////////
    // Levels 1 to split
    ////////////////////

    always_comb begin
        g_lvl[0] = pg_in.g;
        a_lvl[0] = pg_in.a;
        for (int lvl = 1; lvl <= `KS_SPLIT_LEVEL; lvl++) begin
            prefix_level(
                lvl,
                pg_in.cin,
                g_lvl[lvl-1],
                a_lvl[lvl-1],
                g_lvl[lvl],
                a_lvl[lvl]
            );
        end
    end

    ////////////////////
    // Middle register
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mid.g   <= '0;
            mid.a   <= '0;
            mid.p   <= '0;
            mid.cin <= 1'b0;
        end else begin
            mid.g   <= g_lvl[`KS_SPLIT_LEVEL];
            mid.a   <= a_lvl[`KS_SPLIT_LEVEL];
            // Propagate and carry-in are only delayed here
            mid.p   <= pg_in.p;
            mid.cin <= pg_in.cin;
        end
    end

endmodule

/* ks_pg_stage.sv */
`timescale 1ns/10ps
`include "ks_params.svh"

module ks_pg_stage import ks_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  operand_t a,
    input  operand_t b,
    input  logic     cin,
    ks_group_if.src  pg
);

    pg_word_t gen_w;
    pg_word_t alive_w;
    pg_word_t prop_w;

    ////////////////////
    // Entry cells
    ////////////////////

    for (genvar i = 0; i < `KS_WIDTH; i++) begin : g_entry
        // Both bits set
        assign gen_w[i]   = a[i] & b[i];
        // Either bit set, so a carry into this bit passes on
        assign alive_w[i] = a[i] | b[i];
        assign prop_w[i]  = a[i] ^ b[i];
    end

    ////////////////////
    // Entry register
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pg.g   <= '0;
            pg.a   <= '0;
            pg.p   <= '0;
            pg.cin <= 1'b0;
        end else begin
            pg.g   <= gen_w;
            pg.a   <= alive_w;
            pg.p   <= prop_w;
            pg.cin <= cin;
        end
    end

endmodule

/* ks_group_if.sv */
`timescale 1ns/10ps

interface ks_group_if import ks_pkg::*; ();

    // Group generate and alive through the prefix levels
    pg_word_t g;
    pg_word_t a;

    // Bit propagate carried along for the sum
    pg_word_t p;

    logic     cin;

    modport src (
        output g,
        output a,
        output p,
        output cin
    );

    modport dst (
        input g,
        input a,
        input p,
        input cin
    );

endinterface

/* ks_pkg.sv */
package ks_pkg;

    `include "ks_params.svh"

    ////////////////////
    // Word types
    ////////////////////

    // Operand or sum word
    typedef logic [`KS_WIDTH-1:0] operand_t;

    // Generate, alive or propagate word, one bit per position
    typedef logic [`KS_WIDTH-1:0] pg_word_t;

    ////////////////////
    // Dot cells
    ////////////////////

    // Grey dot folds the lower group or the carry-in into the upper group
    function automatic logic grey_dot(
        input logic g_hi,
        input logic a_hi,
        input logic g_lo
    );
        return g_hi | (a_hi & g_lo);
    endfunction

    // One Kogge-Stone level with span 2**(lvl-1)
    // Positions below span-1 are already final and pass through
    function automatic void prefix_level(
        input  int       lvl,
        input  logic     cin,
        input  pg_word_t g_in,
        input  pg_word_t a_in,
        output pg_word_t g_out,
        output pg_word_t a_out
    );
        int span;

        span  = 1 << (lvl - 1);
        g_out = g_in;
        a_out = a_in;
        for (int i = span - 1; i < `KS_WIDTH; i++) begin
            if (i == span - 1) begin
                // Lowest live position picks up the carry-in
                g_out[i] = grey_dot(g_in[i], a_in[i], cin);
            end else begin
                g_out[i] = grey_dot(g_in[i], a_in[i], g_in[i-span]);
            end
            // White dots also merge alive
            if (i >= 2 * span - 1) begin
                a_out[i] = a_in[i] & a_in[i-span];
            end
        end
    endfunction

endpackage

/* ks_params.svh */
`ifndef KS_PARAMS_SVH
`define KS_PARAMS_SVH

// Operand width and prefix tree depth
`define KS_WIDTH       32
`define KS_LEVELS      5

// Last prefix level ahead of the middle register
`define KS_SPLIT_LEVEL 3

// Cycles from operands to sum and cout
`define KS_LATENCY     3

`endif
